/* flist.f */
+incdir+common
common/msi_ptw_pkg.sv
common/pte_beat_if.sv
common/msi_verdict_if.sv
src/msi_fetch.sv
src/msi_pte_check.sv
src/msi_result.sv
src/msi_ptw_top.sv
tests/msi_ptw_chk.sv
tests/msi_ptw_tb.sv

/* tests/msi_ptw_tb.sv */
`timescale 1ns/10ps
`include "msi_ptw_macros.svh"

module msi_ptw_tb;

    // Each scenario kind runs twice
    localparam int NUM_KINDS   = 12;
    localparam int NUM_SCEN    = 2 * NUM_KINDS;
    localparam int K_FLAT      = 0;
    localparam int K_MRIF      = 1;
    localparam int K_V_CLEAR   = 2;
    localparam int K_C_SET     = 3;
    localparam int K_BAD_MODE  = 4;
    localparam int K_FLAT_RSV  = 5;
    localparam int K_MRIF_RSV0 = 6;
    localparam int K_MRIF_RSV1 = 7;
    localparam int K_ERR_BEAT0 = 8;
    localparam int K_ERR_BEAT1 = 9;
    localparam int K_RX        = 10;
    localparam int K_IGNORE    = 11;

    logic                          clk_i;
    logic                          rst_ni;
    logic                          init_i;
    logic                          is_rx_i;
    logic [`MSI_GPA_PPN_W+11:0]    req_iova_i;
    logic [`MSI_PPN_W-1:0]         msiptp_ppn_i;
    logic [`MSI_MASK_W-1:0]        msi_addr_mask_i;
    logic                          ar_valid_o;
    logic                          ar_ready_i;
    logic [`MSI_PLEN-1:0]          ar_addr_o;
    logic                          r_valid_i;
    logic [63:0]                   r_data_i;
    logic                          r_resp_err_i;
    logic                          r_last_i;
    logic                          iotlb_update_o;
    logic [`MSI_GPA_PPN_W-1:0]     iotlb_vpn_o;
    logic [`MSI_PPN_W-1:0]         iotlb_ppn_o;
    logic                          mrifc_update_o;
    logic [`MSI_MRIF_ADDR_W-1:0]   mrifc_addr_o;
    logic [`MSI_PPN_W-1:0]         mrifc_nppn_o;
    logic [10:0]                   mrifc_nid_o;
    logic                          ignore_o;
    logic                          error_o;
    logic [`MSI_CAUSE_W-1:0]       cause_o;
    logic [31:0]                   lfsr_q;
    int                            scen;

    msi_ptw_top dut (.*);

    // 4 ns clock
    initial clk_i = 1'b0;
    always #2 clk_i = ~clk_i;

    // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v      = {v[62:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // Expected file number with the highest mask bit shifted in first
    function automatic logic [15:0] gather_mask_bits(input logic [28:0] ppn,
                                                     input logic [15:0] mask);
        logic [15:0] r;
        int          i;
        r = '0;
        for (i = 15; i >= 0; i--) begin
            if (mask[i]) begin
                r = {r[14:0], ppn[i]};
            end
        end
        return r;
    endfunction

    task automatic stop_failed();
        $display("Test failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t: %s got 0x%0h expected 0x%0h",
                     $time, name, got, exp);
            stop_failed();
        end
    endtask

    // One walk from trigger to outcome
    task automatic run_walk(input int kind);
        logic [63:0]  w0;
        logic [63:0]  w1;
        logic [40:0]  iova;
        logic [43:0]  base;
        logic [43:0]  ppn;
        logic [43:0]  nppn;
        logic [46:0]  maddr;
        logic [10:0]  nid;
        logic [15:0]  mask;
        logic [1:0]   mode;
        logic         mrif;
        logic [3:0]   exp_pulses;
        logic [10:0]  exp_cause;
        int           stall;
        int           pick;
        iova  = 41'(take_bits(41));
        base  = 44'(take_bits(44));
        mask  = 16'(take_bits(16));
        ppn   = 44'(take_bits(44));
        maddr = 47'(take_bits(47));
        nppn  = 44'(take_bits(44));
        nid   = 11'(take_bits(11));
        stall = int'(take_bits(3));
        case (kind)
            K_FLAT, K_FLAT_RSV: mrif = 1'b0;
            K_MRIF, K_MRIF_RSV0, K_MRIF_RSV1, K_ERR_BEAT1, K_IGNORE: mrif = 1'b1;
            default: mrif = take_bits(1) != 0;
        endcase
        // MRIF walks need a whole-word access unless discarded
        if (mrif && kind != K_IGNORE) begin
            iova[11:0] = 12'h0;
        end
        if (kind == K_IGNORE && iova[11:0] == 12'h0) begin
            iova[0] = 1'b1;
        end
        mode = mrif ? `MSI_MODE_MRIF : `MSI_MODE_FLAT;
        if (kind == K_BAD_MODE) begin
            // Modes 0 and 2
            mode = {take_bits(1) != 0, 1'b0};
        end
        if (mrif) begin
            w0 = {1'b0, 9'h0, maddr, 4'h0, mode, 1'b1};
        end else begin
            w0 = {1'b0, 9'h0, ppn, 7'h0, mode, 1'b1};
        end
        w1 = {3'h0, nid[10], 6'h0, nid[9:0], nppn};
        // Fault injection with one random reserved bit
        case (kind)
            K_V_CLEAR: w0[0] = 1'b0;
            K_C_SET: w0[63] = 1'b1;
            K_FLAT_RSV: begin
                pick = int'(take_bits(4));
                w0   = w0 | (64'd1 << (pick < 7 ? 3 + pick : 47 + pick));
            end
            K_MRIF_RSV0: begin
                pick = int'(take_bits(4) % 13);
                w0   = w0 | (64'd1 << (pick < 4 ? 3 + pick : 50 + pick));
            end
            K_MRIF_RSV1: begin
                pick = int'(take_bits(4) % 9);
                w1   = w1 | (64'd1 << (pick < 6 ? 54 + pick : 55 + pick));
            end
            default: begin
            end
        endcase
        // Pulse order iotlb, mrifc, ignore, error
        case (kind)
            K_FLAT: exp_pulses = 4'b1000;
            K_MRIF: exp_pulses = 4'b0100;
            K_IGNORE: exp_pulses = 4'b0010;
            default: exp_pulses = 4'b0001;
        endcase
        case (kind)
            K_V_CLEAR, K_C_SET: exp_cause = `MSI_CAUSE_PTE_INVALID;
            K_ERR_BEAT0, K_ERR_BEAT1: exp_cause = `MSI_CAUSE_DATA_CORRUPT;
            K_RX: exp_cause = `MSI_CAUSE_INSTR_FAULT;
            default: exp_cause = `MSI_CAUSE_PTE_MISCONF;
        endcase

        @(posedge clk_i);
        init_i          <= 1'b1;
        is_rx_i         <= (kind == K_RX);
        req_iova_i      <= iova;
        msiptp_ppn_i    <= base;
        msi_addr_mask_i <= mask;
        @(posedge clk_i);
        init_i <= 1'b0;
        @(negedge clk_i);
        if (kind == K_RX) begin
            // No read at all and a fault two cycles after the trigger
            check_value("ar_valid_o", ar_valid_o, 1'b0);
            @(posedge clk_i);
            @(negedge clk_i);
            check_value("ar_valid_o", ar_valid_o, 1'b0);
        end else begin
            check_value("ar_valid_o", ar_valid_o, 1'b1);
            check_value("ar_addr_o", ar_addr_o,
                        {base, 12'h0} | {gather_mask_bits(iova[40:12], mask), 4'h0});
            // Random stall on the address channel
            repeat (stall + 1) @(posedge clk_i);
            ar_ready_i <= 1'b1;
            @(posedge clk_i);
            ar_ready_i   <= 1'b0;
            r_valid_i    <= 1'b1;
            r_data_i     <= w0;
            r_resp_err_i <= (kind == K_ERR_BEAT0);
            r_last_i     <= 1'b0;
            @(posedge clk_i);
            r_data_i     <= w1;
            r_resp_err_i <= (kind == K_ERR_BEAT1);
            r_last_i     <= 1'b1;
            @(posedge clk_i);
            r_valid_i    <= 1'b0;
            r_resp_err_i <= 1'b0;
            r_last_i     <= 1'b0;
            // Outcome two cycles after the last beat
            @(posedge clk_i);
            @(negedge clk_i);
        end
        check_value("iotlb_update_o", iotlb_update_o, exp_pulses[3]);
        check_value("mrifc_update_o", mrifc_update_o, exp_pulses[2]);
        check_value("ignore_o", ignore_o, exp_pulses[1]);
        check_value("error_o", error_o, exp_pulses[0]);
        if (exp_pulses[0]) begin
            check_value("cause_o", cause_o, exp_cause);
        end
        if (kind == K_FLAT) begin
            check_value("iotlb_ppn_o", iotlb_ppn_o, ppn);
            check_value("iotlb_vpn_o", iotlb_vpn_o, iova[40:12]);
        end
        if (kind == K_MRIF) begin
            check_value("mrifc_addr_o", mrifc_addr_o, maddr);
            check_value("mrifc_nppn_o", mrifc_nppn_o, nppn);
            check_value("mrifc_nid_o", mrifc_nid_o, nid);
        end
    endtask

    initial begin
        lfsr_q          = 32'hd18e;
        rst_ni          = 1'b0;
        init_i          = 1'b0;
        is_rx_i         = 1'b0;
        req_iova_i      = '0;
        msiptp_ppn_i    = '0;
        msi_addr_mask_i = '0;
        ar_ready_i      = 1'b0;
        r_valid_i       = 1'b0;
        r_data_i        = '0;
        r_resp_err_i    = 1'b0;
        r_last_i        = 1'b0;
        repeat (4) @(posedge clk_i);
        rst_ni <= 1'b1;
        for (scen = 0; scen < NUM_SCEN; scen++) begin
            run_walk(scen % NUM_KINDS);
        end
        repeat (4) @(posedge clk_i);
        // Protocol checker errors counted in the bound module
        if (dut.u_chk.err_cnt == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("Protocol checker reported %0d errors", dut.u_chk.err_cnt);
            stop_failed();
        end
    end

    // Protocol errors from the bound checker
    initial begin
        wait (dut.u_chk.err_cnt != 0);
        $display("Protocol checker reported an error at %0t", $time);
        stop_failed();
    end

    // Watchdog allows 40 cycles per scenario
    initial begin
        repeat (NUM_SCEN * 40) @(posedge clk_i);
        $display("Timeout: walks did not finish within %0d cycles", NUM_SCEN * 40);
        stop_failed();
    end

endmodule

/* tests/msi_ptw_chk.sv */
`timescale 1ns/10ps
`include "msi_ptw_macros.svh"

module msi_ptw_chk (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   ar_valid_i,
    input  logic                   ar_ready_i,
    input  logic [`MSI_PLEN-1:0]   ar_addr_i,
    input  logic                   iotlb_update_i,
    input  logic                   mrifc_update_i,
    input  logic                   ignore_i,
    input  logic                   error_i
);

    // Failure count, read by the testbench at the end
    int         err_cnt = 0;
    logic [3:0] pulses;

    assign pulses = {iotlb_update_i, mrifc_update_i, ignore_i, error_i};

    // Quiet outputs right after reset release
    assert property (@(posedge clk_i) $rose(rst_ni) |-> !ar_valid_i && pulses == 4'b0)
        else begin
            $error("Outputs active straight after reset");
            err_cnt++;
        end

    // Address held until accepted
    assert property (@(posedge clk_i) disable iff (!rst_ni)
                     ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_addr_i))
        else begin
            $error("Read address dropped or changed before ar_ready");
            err_cnt++;
        end

    // Never two outcomes together
    assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(pulses))
        else begin
            $error("More than one outcome pulse in a cycle");
            err_cnt++;
        end

    // Single-cycle pulses
    assert property (@(posedge clk_i) disable iff (!rst_ni) (|pulses) |=> pulses == 4'b0)
        else begin
            $error("Outcome pulse longer than one cycle");
            err_cnt++;
        end

endmodule

bind msi_ptw_top msi_ptw_chk u_chk (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .ar_valid_i     (ar_valid_o),
    .ar_ready_i     (ar_ready_i),
    .ar_addr_i      (ar_addr_o),
    .iotlb_update_i (iotlb_update_o),
    .mrifc_update_i (mrifc_update_o),
    .ignore_i       (ignore_o),
    .error_i        (error_o)
);

/* src/msi_ptw_top.sv */
`timescale 1ns/10ps
`include "msi_ptw_macros.svh"

module msi_ptw_top (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    // Trigger and request
    input  logic                          init_i,
    input  logic                          is_rx_i,
    input  logic [`MSI_GPA_PPN_W+11:0]    req_iova_i,
    input  logic [`MSI_PPN_W-1:0]         msiptp_ppn_i,
    input  logic [`MSI_MASK_W-1:0]        msi_addr_mask_i,
    // Read address channel
    output logic                          ar_valid_o,
    input  logic                          ar_ready_i,
    output logic [`MSI_PLEN-1:0]          ar_addr_o,
    // Read data channel, always ready
    input  logic                          r_valid_i,
    input  logic [63:0]                   r_data_i,
    input  logic                          r_resp_err_i,
    input  logic                          r_last_i,
    // Outcomes
    output logic                          iotlb_update_o,
    output logic [`MSI_GPA_PPN_W-1:0]     iotlb_vpn_o,
    output logic [`MSI_PPN_W-1:0]         iotlb_ppn_o,
    output logic                          mrifc_update_o,
    output logic [`MSI_MRIF_ADDR_W-1:0]   mrifc_addr_o,
    output logic [`MSI_PPN_W-1:0]         mrifc_nppn_o,
    output logic [10:0]                   mrifc_nid_o,
    output logic                          ignore_o,
    output logic                          error_o,
    output logic [`MSI_CAUSE_W-1:0]       cause_o
);

    pte_beat_if    u_beat_if ();
    msi_verdict_if u_vd_if ();

    msi_fetch u_fetch (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .init_i          (init_i),
        .is_rx_i         (is_rx_i),
        .req_iova_i      (req_iova_i),
        .msiptp_ppn_i    (msiptp_ppn_i),
        .msi_addr_mask_i (msi_addr_mask_i),
        .ar_ready_i      (ar_ready_i),
        .ar_valid_o      (ar_valid_o),
        .ar_addr_o       (ar_addr_o),
        .r_valid_i       (r_valid_i),
        .r_data_i        (r_data_i),
        .r_resp_err_i    (r_resp_err_i),
        .r_last_i        (r_last_i),
        .beat            (u_beat_if.source)
    );

    msi_pte_check u_check (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .beat   (u_beat_if.sink),
        .vd     (u_vd_if.source)
    );

    msi_result u_result (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .vd             (u_vd_if.sink),
        .iotlb_update_o (iotlb_update_o),
        .iotlb_vpn_o    (iotlb_vpn_o),
        .iotlb_ppn_o    (iotlb_ppn_o),
        .mrifc_update_o (mrifc_update_o),
        .mrifc_addr_o   (mrifc_addr_o),
        .mrifc_nppn_o   (mrifc_nppn_o),
        .mrifc_nid_o    (mrifc_nid_o),
        .ignore_o       (ignore_o),
        .error_o        (error_o),
        .cause_o        (cause_o)
    );

endmodule

/* src/msi_result.sv */
`timescale 1ns/10ps
`include "msi_ptw_macros.svh"

module msi_result (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    msi_verdict_if.sink                   vd,
    output logic                          iotlb_update_o,
    output logic [`MSI_GPA_PPN_W-1:0]     iotlb_vpn_o,
    output logic [`MSI_PPN_W-1:0]         iotlb_ppn_o,
    output logic                          mrifc_update_o,
    output logic [`MSI_MRIF_ADDR_W-1:0]   mrifc_addr_o,
    output logic [`MSI_PPN_W-1:0]         mrifc_nppn_o,
    output logic [10:0]                   mrifc_nid_o,
    output logic                          ignore_o,
    output logic                          error_o,
    output logic [`MSI_CAUSE_W-1:0]       cause_o
);

    // One-hot pulses, one per verdict
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            iotlb_update_o <= 1'b0;
            mrifc_update_o <= 1'b0;
            ignore_o       <= 1'b0;
            error_o        <= 1'b0;
        end else begin
            iotlb_update_o <= vd.verdict_valid && (vd.verdict == msi_ptw_pkg::VERDICT_FLAT);
            mrifc_update_o <= vd.verdict_valid && (vd.verdict == msi_ptw_pkg::VERDICT_MRIF);
            ignore_o       <= vd.verdict_valid && (vd.verdict == msi_ptw_pkg::VERDICT_IGNORE);
            error_o        <= vd.verdict_valid && (vd.verdict == msi_ptw_pkg::VERDICT_FAULT);
        end
    end

    // Entry fields, held until the next outcome
    always_ff @(posedge clk_i) begin
        if (vd.verdict_valid) begin
            iotlb_vpn_o  <= vd.gpa_ppn;
            // Flat view for the IOTLB
            iotlb_ppn_o  <= vd.word0.flat.ppn;
            // MRIF view for the MRIF cache
            mrifc_addr_o <= vd.word0.mrif.addr;
            mrifc_nppn_o <= vd.notice.nppn;
            // NID split across two fields
            mrifc_nid_o  <= {vd.notice.nid_10, vd.notice.nid_9_0};
            cause_o      <= vd.cause;
        end
    end

endmodule

/* src/msi_pte_check.sv */
`timescale 1ns/10ps
`include "msi_ptw_macros.svh"

module msi_pte_check (
    input  logic           clk_i,
    input  logic           rst_ni,
    pte_beat_if.sink       beat,
    msi_verdict_if.source  vd
);

    msi_ptw_pkg::msi_pte_word0_u   w0;
    msi_ptw_pkg::msi_pte_notice_t  nt;
    msi_ptw_pkg::msi_verdict_e     dec_q, dec_d;
    logic [`MSI_CAUSE_W-1:0]       cause_q, cause_d;
    logic                          need_q, need_d;
    logic                          valid_q;
    msi_ptw_pkg::msi_pte_word0_u   word0_q;
    msi_ptw_pkg::msi_pte_notice_t  notice_q;

    // Same beat read as either doubleword
    assign w0 = msi_ptw_pkg::msi_pte_word0_u'(beat.beat_data);
    assign nt = msi_ptw_pkg::msi_pte_notice_t'(beat.beat_data);

    always_comb begin
        dec_d   = dec_q;
        cause_d = cause_q;
        need_d  = need_q;
        if (beat.beat_valid && beat.beat_first) begin
            need_d = 1'b0;
            dec_d  = msi_ptw_pkg::VERDICT_FAULT;
            // V and C sit at the same place in both views
            if (!w0.flat.v || w0.flat.c) begin
                cause_d = `MSI_CAUSE_PTE_INVALID;
            end else if (beat.beat_err) begin
                cause_d = `MSI_CAUSE_DATA_CORRUPT;
            end else if (w0.flat.mode == `MSI_MODE_FLAT) begin
                if (|w0.flat.rsv_1 || |w0.flat.rsv_2) begin
                    cause_d = `MSI_CAUSE_PTE_MISCONF;
                end else begin
                    dec_d = msi_ptw_pkg::VERDICT_FLAT;
                end
            end else if (w0.mrif.mode == `MSI_MODE_MRIF) begin
                if (|w0.mrif.rsv_1 || |w0.mrif.rsv_2) begin
                    cause_d = `MSI_CAUSE_PTE_MISCONF;
                end else if (|beat.iova_offset) begin
                    // Partial access to an MRIF, dropped silently
                    dec_d = msi_ptw_pkg::VERDICT_IGNORE;
                end else begin
                    // Outcome depends on the notice word
                    need_d = 1'b1;
                end
            end else begin
                // Reserved modes 0 and 2
                cause_d = `MSI_CAUSE_PTE_MISCONF;
            end
        end else if (beat.beat_valid && need_q) begin
            need_d = 1'b0;
            dec_d  = msi_ptw_pkg::VERDICT_FAULT;
            if (beat.beat_err) begin
                cause_d = `MSI_CAUSE_DATA_CORRUPT;
            end else if (|nt.rsv_1 || |nt.rsv_2) begin
                cause_d = `MSI_CAUSE_PTE_MISCONF;
            end else begin
                dec_d = msi_ptw_pkg::VERDICT_MRIF;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            dec_q   <= msi_ptw_pkg::VERDICT_FAULT;
            cause_q <= '0;
            need_q  <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            // Verdict pulse after the burst drains or on abort
            valid_q <= beat.rx_abort || (beat.beat_valid && beat.beat_last);
            if (beat.rx_abort) begin
                dec_q   <= msi_ptw_pkg::VERDICT_FAULT;
                cause_q <= `MSI_CAUSE_INSTR_FAULT;
                need_q  <= 1'b0;
            end else if (beat.beat_valid) begin
                dec_q   <= dec_d;
                cause_q <= cause_d;
                need_q  <= need_d;
            end
        end
    end

    // Raw doublewords, decoded downstream
    always_ff @(posedge clk_i) begin
        if (beat.beat_valid && beat.beat_first) begin
            word0_q <= w0;
        end
        if (beat.beat_valid && !beat.beat_first) begin
            notice_q <= nt;
        end
    end

    assign vd.verdict_valid = valid_q;
    assign vd.verdict       = dec_q;
    assign vd.cause         = cause_q;
    assign vd.word0         = word0_q;
    assign vd.notice        = notice_q;
    assign vd.gpa_ppn       = beat.gpa_ppn;

endmodule

/* src/msi_fetch.sv */
`timescale 1ns/10ps
`include "msi_ptw_macros.svh"

module msi_fetch (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          init_i,
    input  logic                          is_rx_i,
    input  logic [`MSI_GPA_PPN_W+11:0]    req_iova_i,
    input  logic [`MSI_PPN_W-1:0]         msiptp_ppn_i,
    input  logic [`MSI_MASK_W-1:0]        msi_addr_mask_i,
    input  logic                          ar_ready_i,
    output logic                          ar_valid_o,
    output logic [`MSI_PLEN-1:0]          ar_addr_o,
    input  logic                          r_valid_i,
    input  logic [63:0]                   r_data_i,
    input  logic                          r_resp_err_i,
    input  logic                          r_last_i,
    pte_beat_if.source                    beat
);

    // WAIT covers the cycle between burst end and the outcome
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_DATA,
        ST_WAIT
    } state_t;

    state_t                      state_q, state_d;
    logic                        trigger;
    logic [`MSI_MASK_W-1:0]      imsic_num;
    logic [`MSI_PLEN-1:0]        pptr_q;
    logic [11:0]                 offset_q;
    logic [`MSI_GPA_PPN_W-1:0]   gpa_ppn_q;
    logic                        first_q;

    // New walk only from idle
    assign trigger = (state_q == ST_IDLE) && init_i;

    // Interrupt file number from the GPA PPN
    assign imsic_num = msi_ptw_pkg::extract_imsic_num(req_iova_i[`MSI_GPA_PPN_W+11:12],
                                                      msi_addr_mask_i);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                // Read-for-execute skips the memory access
                if (init_i) begin
                    state_d = is_rx_i ? ST_WAIT : ST_ADDR;
                end
            end
            ST_ADDR: begin
                if (ar_ready_i) begin
                    state_d = ST_DATA;
                end
            end
            ST_DATA: begin
                if (r_valid_i && r_last_i) begin
                    state_d = ST_WAIT;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= ST_IDLE;
            first_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // Armed by the address handshake, cleared by the first beat
            if (state_q == ST_ADDR && ar_ready_i) begin
                first_q <= 1'b1;
            end else if (state_q == ST_DATA && r_valid_i) begin
                first_q <= 1'b0;
            end
        end
    end

    // Request payload, latched once per walk
    always_ff @(posedge clk_i) begin
        if (trigger) begin
            // Base page ORed with 16-byte PTE index
            pptr_q    <= {msiptp_ppn_i, 12'b0} | `MSI_PLEN'({imsic_num, 4'b0});
            offset_q  <= req_iova_i[11:0];
            gpa_ppn_q <= req_iova_i[`MSI_GPA_PPN_W+11:12];
        end
    end

    assign ar_valid_o = (state_q == ST_ADDR);
    assign ar_addr_o  = pptr_q;

    // Beats forwarded in the cycle they arrive
    assign beat.beat_valid  = (state_q == ST_DATA) && r_valid_i;
    assign beat.beat_first  = first_q;
    assign beat.beat_data   = r_data_i;
    assign beat.beat_err    = r_resp_err_i;
    assign beat.beat_last   = r_last_i;
    assign beat.rx_abort    = trigger && is_rx_i;
    assign beat.iova_offset = offset_q;
    assign beat.gpa_ppn     = gpa_ppn_q;

endmodule

/* common/msi_verdict_if.sv */
`timescale 1ns/10ps
`include "msi_ptw_macros.svh"

// Decision of the PTE checker and the fields behind it
interface msi_verdict_if;

    // One-cycle pulse
    logic                          verdict_valid;
    msi_ptw_pkg::msi_verdict_e     verdict;
    logic [`MSI_CAUSE_W-1:0]       cause;
    msi_ptw_pkg::msi_pte_word0_u   word0;
    msi_ptw_pkg::msi_pte_notice_t  notice;
    logic [`MSI_GPA_PPN_W-1:0]     gpa_ppn;

    modport source (output verdict_valid, verdict, cause, word0, notice, gpa_ppn);
    modport sink (input verdict_valid, verdict, cause, word0, notice, gpa_ppn);

endinterface

/* common/pte_beat_if.sv */
`timescale 1ns/10ps
`include "msi_ptw_macros.svh"

// Fetched beats plus the latched request facts
interface pte_beat_if;

    logic                         beat_valid;
    logic                         beat_first;
    logic [63:0]                  beat_data;
    logic                         beat_err;
    logic                         beat_last;
    // Read-for-execute, no memory access
    logic                         rx_abort;
    logic [11:0]                  iova_offset;
    logic [`MSI_GPA_PPN_W-1:0]    gpa_ppn;

    modport source (output beat_valid, beat_first, beat_data, beat_err, beat_last,
                    rx_abort, iova_offset, gpa_ppn);
    modport sink (input beat_valid, beat_first, beat_data, beat_err, beat_last,
                  rx_abort, iova_offset, gpa_ppn);

endinterface

/* common/msi_ptw_pkg.sv */
`include "msi_ptw_macros.svh"

package msi_ptw_pkg;

    // Flat mode PTE, first doubleword
    typedef struct packed {
        logic                    c;
        logic [8:0]              rsv_2;
        logic [`MSI_PPN_W-1:0]   ppn;
        logic [6:0]              rsv_1;
        logic [1:0]              mode;
        logic                    v;
    } msi_pte_flat_t;

    // MRIF mode PTE, first doubleword
    typedef struct packed {
        logic                        c;
        logic [8:0]                  rsv_2;
        logic [`MSI_MRIF_ADDR_W-1:0] addr;
        logic [3:0]                  rsv_1;
        logic [1:0]                  mode;
        logic                        v;
    } msi_pte_mrif_t;

    // First doubleword seen both ways, V, mode and C line up
    typedef union packed {
        msi_pte_flat_t flat;
        msi_pte_mrif_t mrif;
    } msi_pte_word0_u;

    // MRIF mode PTE, second doubleword
    typedef struct packed {
        logic [2:0]            rsv_2;
        logic                  nid_10;
        logic [5:0]            rsv_1;
        logic [9:0]            nid_9_0;
        logic [`MSI_PPN_W-1:0] nppn;
    } msi_pte_notice_t;

    // Outcome of one walk
    typedef enum logic [2:0] {
        VERDICT_FLAT   = 3'd0,
        VERDICT_MRIF   = 3'd1,
        VERDICT_IGNORE = 3'd2,
        VERDICT_FAULT  = 3'd3
    } msi_verdict_e;

    // Gather PPN bits under set mask bits, lowest first
    function automatic logic [`MSI_MASK_W-1:0] extract_imsic_num(
        input logic [`MSI_GPA_PPN_W-1:0] ppn,
        input logic [`MSI_MASK_W-1:0]    mask
    );
        logic [`MSI_MASK_W-1:0] num;
        int unsigned            k;
        num = '0;
        k   = 0;
        for (int i = 0; i < `MSI_MASK_W; i++) begin
            if (mask[i]) begin
                num[k] = ppn[i];
                k      = k + 1;
            end
        end
        return num;
    endfunction

endpackage

/* common/msi_ptw_macros.svh */
`ifndef MSI_PTW_MACROS_SVH
`define MSI_PTW_MACROS_SVH

// Request PPN width, GPA bits 40:12
`define MSI_GPA_PPN_W 29
// Physical page number and address widths
`define MSI_PPN_W 44
`define MSI_PLEN 56
// MSI address mask
`define MSI_MASK_W 16
// Cause code width
`define MSI_CAUSE_W 11
// MRIF address field, bits 53:7 of the PTE
`define MSI_MRIF_ADDR_W 47

// Fault causes
`define MSI_CAUSE_INSTR_FAULT 11'd1
`define MSI_CAUSE_PTE_INVALID 11'd262
`define MSI_CAUSE_PTE_MISCONF 11'd263
`define MSI_CAUSE_DATA_CORRUPT 11'd270

// PTE mode field
`define MSI_MODE_FLAT 2'd3
`define MSI_MODE_MRIF 2'd1

`endif
